// File: vlog.f
common/wbConfigPkg.sv
common/wbPacketPkg.sv
writeback/execLane.sv
writeback/lsuLane.sv
writeback/branchResolve.sv
writeback/writeBack.sv
tb/clockGen.sv
tb/writeBack_checker.sv
tb/wbTb.sv

// File: run.sh
#!/bin/sh
# Build the writeback testbench with Verilator, run it and scan the log for failure

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module wbTb -f vlog.f -o wbSim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/wbSim +verilator+error+limit+1000 > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "Simulation finished: FAIL" sim.log; then
    exit 1
fi
exit 0

// File: tb/wbTb.sv
// Writeback stage testbench: random lane traffic checked against a one-cycle reference model

`timescale 1ns/1ps

module wbTb;

        localparam int cycles   = 400;
        localparam int watchdog = cycles + 100;         // in clock periods
        localparam int lanes    = wbConfigPkg::execLanes + 1;
        localparam int br       = wbConfigPkg::branchLane;

        logic                                   clk;
        logic                                   reset;
        wbPacketPkg::execPacket_t               execPkt [wbConfigPkg::execLanes];
        wbPacketPkg::lsuPacket_t                lsuPkt;
        wbPacketPkg::ldViolation_t              ldv;
        wbPacketPkg::wbCtrl_t                   wbCtrl [lanes];
        wbPacketPkg::bypass_t                   bypass [lanes];
        wbPacketPkg::iqFree_t                   iqFree;
        wbPacketPkg::ctrlResolve_t              ctrl;
        wbPacketPkg::ldViolation_t              ldvOut;

        // ==============================
        // reference model state
        // ==============================
        wbPacketPkg::execPacket_t               prev [lanes];   // lane 3 holds the lsu fields
        logic [wbConfigPkg::issueQW-1:0]        prevEntry;
        wbPacketPkg::ldViolation_t              expLdv;
        logic                                   ldvKnown = 1'b0;
        logic                                   resetAtEdge = 1'b1;
        int                                     errors = 0;
        int                                     runCycles = 0;
        logic [31:0]                            lcgState = 32'ha90;

        clockGen clockGen_i (.clk_o(clk), .reset_o(reset));

        writeBack dut_i
        (
                .clk           (clk),
                .reset         (reset),
                .execPkt_i     (execPkt),
                .lsuPkt_i      (lsuPkt),
                .ldViolation_i (ldv),
                .wbCtrl_o      (wbCtrl),
                .bypass_o      (bypass),
                .iqFree_o      (iqFree),
                .ctrl_o        (ctrl),
                .ldViolation_o (ldvOut)
        );

        bind writeBack writeBack_checker wbChecker_i
        (
                .clk(clk), .reset(reset), .execPkt_i(execPkt_i), .lsuPkt_i(lsuPkt_i),
                .wbCtrl_i(wbCtrl_o), .iqFree_i(iqFree_o), .ctrl_i(ctrl_o),
                .ldViolationOut_i(ldViolation_o)
        );

        function automatic logic [31:0] nextRand();
                lcgState = lcgState * 32'd1103515245 + 32'd12345;
                return lcgState;
        endfunction

        function automatic wbPacketPkg::execPacket_t randomExec(input logic branch);
                wbPacketPkg::execPacket_t       p;
                logic [31:0]                    r;
                r                   = nextRand();
                p.valid             = r[31:30] != 2'b00;
                p.branchMask        = r[29:26];
                p.flags.mispredict  = branch & (r[25:24] == 2'b00);     // about one in four
                p.flags.conditional = r[23];
                p.flags.bypassEn    = r[22];
                p.flags.wbFlags     = r[21:18];
                p.physReg           = r[17:11];
                p.data              = nextRand();
                p.target            = nextRand();
                r                   = nextRand();
                p.activeListId      = r[31:25];
                p.checkpointId      = r[24:23];
                p.ctiIndex          = r[22:19];
                p.direction         = r[18];
                return p;
        endfunction

        task automatic checkValue(input string name, input logic [63:0] expected,
                                  input logic [63:0] actual);
                assert (expected == actual)
                else
                begin
                        errors++;
                        $display("[ERROR] %s: expected %0h actual %0h", name, expected, actual);
                end
        endtask

        // inputs on the pins now were taken at the last rising edge
        task automatic updateModel();
                for (int l = 0; l < wbConfigPkg::execLanes; l++)
                begin
                        prev[l]       = execPkt[l];
                        prev[l].valid = execPkt[l].valid & ~resetAtEdge;
                end
                prev[3]              = '0;
                prev[3].valid        = lsuPkt.valid & ~resetAtEdge;
                prev[3].branchMask   = lsuPkt.branchMask;
                prev[3].flags        = lsuPkt.flags;
                prev[3].physReg      = lsuPkt.physReg;
                prev[3].activeListId = lsuPkt.activeListId;
                prev[3].data         = lsuPkt.data;
                prevEntry            = lsuPkt.iqEntry;
                if (lsuPkt.valid)
                begin
                        expLdv   = ldv;
                        ldvKnown = 1'b1;
                end
                if (resetAtEdge)
                        expLdv.valid = 1'b0;
        endtask

        task automatic checkOutputs();
                logic                                   squashValid;
                logic [wbConfigPkg::checkpointW-1:0]    squashId;
                squashValid = prev[br].valid & prev[br].flags.mispredict;
                squashId    = prev[br].checkpointId;
                for (int l = 0; l < lanes; l++)
                begin
                        checkValue($sformatf("lane %0d writeback valid", l),
                                64'(prev[l].valid & ~(squashValid & prev[l].branchMask[squashId])),
                                64'(wbCtrl[l].valid));
                        checkValue($sformatf("lane %0d bypass valid", l),
                                64'(prev[l].valid & prev[l].flags.bypassEn), 64'(bypass[l].valid));
                        if (prev[l].valid)
                        begin
                                checkValue($sformatf("lane %0d writeback word", l),
                                        64'({prev[l].activeListId, prev[l].flags.wbFlags}),
                                        64'({wbCtrl[l].activeListId, wbCtrl[l].wbFlags}));
                                checkValue($sformatf("lane %0d bypass tag and data", l),
                                        64'({prev[l].physReg, prev[l].data}),
                                        64'({bypass[l].physReg, bypass[l].data}));
                        end
                end
                checkValue("branch verified", 64'(prev[br].valid), 64'(ctrl.verified));
                checkValue("branch mispredict", 64'(squashValid), 64'(ctrl.mispredict));
                if (prev[br].valid)
                        checkValue("branch resolution fields",
                                64'({prev[br].flags.conditional, prev[br].checkpointId,
                                     prev[br].target, prev[br].direction, prev[br].ctiIndex}),
                                64'({ctrl.conditional, ctrl.checkpointId, ctrl.target,
                                     ctrl.direction, ctrl.ctiIndex}));
                checkValue("iq release valid", 64'(prev[3].valid), 64'(iqFree.valid));
                if (prev[3].valid)
                        checkValue("iq release entry", 64'(prevEntry), 64'(iqFree.entry));
                checkValue("load violation valid", 64'(expLdv.valid), 64'(ldvOut.valid));
                if (ldvKnown)
                        checkValue("load violation id", 64'(expLdv.activeListId),
                                64'(ldvOut.activeListId));
        endtask

        task automatic driveInputs();
                wbPacketPkg::execPacket_t       e;
                logic [31:0]                    r;
                for (int l = 0; l < wbConfigPkg::execLanes; l++)
                        execPkt[l] = randomExec(l == br);
                e                   = randomExec(1'b0);
                r                   = nextRand();
                lsuPkt.valid        = e.valid;
                lsuPkt.branchMask   = e.branchMask;
                lsuPkt.flags        = e.flags;
                lsuPkt.data         = e.data;
                lsuPkt.physReg      = e.physReg;
                lsuPkt.activeListId = e.activeListId;
                lsuPkt.iqEntry      = r[31:27];
                ldv.valid           = r[26];
                ldv.activeListId    = r[25:19];
        endtask

        initial
        begin
                for (int l = 0; l < wbConfigPkg::execLanes; l++)
                        execPkt[l] = '0;
                lsuPkt = '0;
                ldv    = '0;
                expLdv = '0;
                for (int c = 0; c < cycles; c++)
                begin
                        @(negedge clk);
                        updateModel();
                        checkOutputs();
                        driveInputs();
                        resetAtEdge = reset;
                        if (!reset)
                                runCycles++;
                end
                if (runCycles == 0)
                begin
                        errors++;
                        $display("reset was never released");
                end
                $display("errors: testbench %0d, checker %0d", errors, dut_i.wbChecker_i.failCount);
                if (errors == 0 && dut_i.wbChecker_i.failCount == 0)
                        $display("Simulation finished: PASS");
                else
                        $display("Simulation finished: FAIL");
                $finish;
        end

        initial
        begin
                for (int t = 0; t < watchdog; t++)
                        #20;
                $display("watchdog expired before the stimulus loop ended");
                $display("Simulation finished: FAIL");
                $finish;
        end

endmodule

// File: tb/writeBack_checker.sv
// Writeback checker bound to the stage top: reset, latency, squash and load/store rules

`timescale 1ns/1ps

module writeBack_checker
(
        input  logic                            clk,
        input  logic                            reset,
        input  wbPacketPkg::execPacket_t        execPkt_i [wbConfigPkg::execLanes],
        input  wbPacketPkg::lsuPacket_t         lsuPkt_i,
        input  wbPacketPkg::wbCtrl_t            wbCtrl_i [wbConfigPkg::execLanes+1],
        input  wbPacketPkg::iqFree_t            iqFree_i,
        input  wbPacketPkg::ctrlResolve_t       ctrl_i,
        input  wbPacketPkg::ldViolation_t       ldViolationOut_i
);

        int unsigned                            failCount = 0;  // failed assertions
        logic [wbConfigPkg::checkpoints-1:0]    maskD;          // lane 0 mask, one cycle back

        always_ff @(posedge clk)
        begin
                maskD <= execPkt_i[0].branchMask;
        end

        resetClears: assert property (@(posedge clk) reset |=>
                !(wbCtrl_i[0].valid | wbCtrl_i[1].valid | wbCtrl_i[2].valid | wbCtrl_i[3].valid)
                && !iqFree_i.valid && !ctrl_i.verified && !ctrl_i.mispredict)
        else
        begin
                failCount++;
                $error("outputs still valid one cycle after reset");
        end

        laneLatency: assert property (@(posedge clk) disable iff (reset) execPkt_i[1].valid
                |=> wbCtrl_i[1].activeListId == $past(execPkt_i[1].activeListId))
        else
        begin
                failCount++;
                $error("lane 1 writeback did not follow its input after one cycle");
        end

        squashKills: assert property (@(posedge clk) disable iff (reset)
                ctrl_i.verified && ctrl_i.mispredict && maskD[ctrl_i.checkpointId]
                |-> !wbCtrl_i[0].valid)
        else
        begin
                failCount++;
                $error("lane 0 writeback survived a mispredict on its checkpoint");
        end

        violationHolds: assert property (@(posedge clk) disable iff (reset)
                !lsuPkt_i.valid |=> $stable(ldViolationOut_i))
        else
        begin
                failCount++;
                $error("load violation word changed without a load/store");
        end

endmodule

// File: tb/clockGen.sv
// Testbench clock and reset source: 20 ns clock, reset held for 8 rising edges

`timescale 1ns/1ps

module clockGen
(
        output logic    clk_o,
        output logic    reset_o
);

        initial
        begin
                clk_o   = 1'b0;
                reset_o = 1'b1;
                repeat (8) @(posedge clk_o);
                #5 reset_o = 1'b0;              // clear of both clock edges
        end

        always #10 clk_o = ~clk_o;

endmodule

// File: writeback/writeBack.sv
// Writeback stage top: three execution lanes, the load/store lane and branch resolution

`timescale 1ns/1ps

module writeBack
(
        input  logic                            clk,
        input  logic                            reset,
        input  wbPacketPkg::execPacket_t        execPkt_i [wbConfigPkg::execLanes],
        input  wbPacketPkg::lsuPacket_t         lsuPkt_i,
        input  wbPacketPkg::ldViolation_t       ldViolation_i,
        output wbPacketPkg::wbCtrl_t            wbCtrl_o [wbConfigPkg::execLanes+1],
        output wbPacketPkg::bypass_t            bypass_o [wbConfigPkg::execLanes+1],
        output wbPacketPkg::iqFree_t            iqFree_o,
        output wbPacketPkg::ctrlResolve_t       ctrl_o,
        output wbPacketPkg::ldViolation_t       ldViolation_o
);

        wbPacketPkg::execPacket_t       held [wbConfigPkg::execLanes];
        wbPacketPkg::squash_t           squash;

        // ==============================
        // execution lanes
        // ==============================
        genvar lane;
        generate
                for (lane = 0; lane < wbConfigPkg::execLanes; lane++)
                begin : execGen
                        execLane execLane_i
                        (
                                .clk      (clk),
                                .reset    (reset),
                                .pkt_i    (execPkt_i[lane]),
                                .squash_i (squash),
                                .wbCtrl_o (wbCtrl_o[lane]),
                                .bypass_o (bypass_o[lane]),
                                .held_o   (held[lane])
                        );
                end
        endgenerate

        // load/store lane sits after the execution lanes
        lsuLane lsuLane_i
        (
                .clk           (clk),
                .reset         (reset),
                .pkt_i         (lsuPkt_i),
                .ldViolation_i (ldViolation_i),
                .squash_i      (squash),
                .wbCtrl_o      (wbCtrl_o[wbConfigPkg::execLanes]),
                .bypass_o      (bypass_o[wbConfigPkg::execLanes]),
                .iqFree_o      (iqFree_o),
                .ldViolation_o (ldViolation_o)
        );

        // ==============================
        // branch resolution
        // ==============================
        branchResolve branchResolve_i
        (
                .held_i   (held[wbConfigPkg::branchLane]),
                .ctrl_o   (ctrl_o),
                .squash_o (squash)
        );

endmodule

// File: writeback/branchResolve.sv
// Branch resolution: decodes the held branch-lane packet into control outputs and squash

`timescale 1ns/1ps

module branchResolve
(
        input  wbPacketPkg::execPacket_t        held_i,
        output wbPacketPkg::ctrlResolve_t       ctrl_o,
        output wbPacketPkg::squash_t            squash_o
);

        logic   verified;
        logic   mispredict;

        assign verified   = held_i.valid;
        assign mispredict = held_i.flags.mispredict;

        always_comb
        begin
                ctrl_o.verified     = verified;
                ctrl_o.mispredict   = verified & mispredict;    // only a live branch
                ctrl_o.conditional  = held_i.flags.conditional;
                ctrl_o.checkpointId = held_i.checkpointId;
                ctrl_o.target       = held_i.target;
                ctrl_o.direction    = held_i.direction;
                ctrl_o.ctiIndex     = held_i.ctiIndex;
        end

        // ==============================
        // squash broadcast to all lanes
        // ==============================
        always_comb
        begin
                squash_o.valid        = verified & mispredict;
                squash_o.checkpointId = held_i.checkpointId;
        end

endmodule

// File: writeback/lsuLane.sv
// Load/store lane writeback: registers the lsu result and violation word, frees its IQ entry

`timescale 1ns/1ps

module lsuLane
(
        input  logic                            clk,
        input  logic                            reset,
        input  wbPacketPkg::lsuPacket_t         pkt_i,
        input  wbPacketPkg::ldViolation_t       ldViolation_i,
        input  wbPacketPkg::squash_t            squash_i,
        output wbPacketPkg::wbCtrl_t            wbCtrl_o,
        output wbPacketPkg::bypass_t            bypass_o,
        output wbPacketPkg::iqFree_t            iqFree_o,
        output wbPacketPkg::ldViolation_t       ldViolation_o
);

        wbPacketPkg::lsuPacket_t        pktQ;
        wbPacketPkg::ldViolation_t      ldViolationQ;
        logic                           killed;

        always_ff @(posedge clk)
        begin
                if (pkt_i.valid)
                begin
                        pktQ         <= pkt_i;
                        ldViolationQ <= ldViolation_i;  // sampled with the load/store only
                end
                if (reset)
                begin
                        pktQ.valid         <= 1'b0;
                        ldViolationQ.valid <= 1'b0;
                end
                else
                begin
                        pktQ.valid <= pkt_i.valid;
                end
        end

        assign killed = squash_i.valid & pktQ.branchMask[squash_i.checkpointId];

        always_comb
        begin
                wbCtrl_o.valid        = pktQ.valid & ~killed;
                wbCtrl_o.activeListId = pktQ.activeListId;
                wbCtrl_o.wbFlags      = pktQ.flags.wbFlags;

                bypass_o.valid        = pktQ.valid & pktQ.flags.bypassEn;
                bypass_o.physReg      = pktQ.physReg;
                bypass_o.data         = pktQ.data;

                iqFree_o.valid        = pktQ.valid;    // entry released even when squashed
                iqFree_o.entry        = pktQ.iqEntry;
        end

        assign ldViolation_o = ldViolationQ;

endmodule

// File: writeback/execLane.sv
// Execution lane writeback: registers one result packet, drives active-list control and bypass

`timescale 1ns/1ps

module execLane
(
        input  logic                            clk,
        input  logic                            reset,
        input  wbPacketPkg::execPacket_t        pkt_i,
        input  wbPacketPkg::squash_t            squash_i,
        output wbPacketPkg::wbCtrl_t            wbCtrl_o,
        output wbPacketPkg::bypass_t            bypass_o,
        output wbPacketPkg::execPacket_t        held_o
);

        wbPacketPkg::execPacket_t       pktQ;
        logic                           killed;

        // payload moves only with a valid packet, valid bit follows every cycle
        always_ff @(posedge clk)
        begin
                if (pkt_i.valid)
                begin
                        pktQ <= pkt_i;
                end
                if (reset)
                begin
                        pktQ.valid <= 1'b0;
                end
                else
                begin
                        pktQ.valid <= pkt_i.valid;
                end
        end

        // ==============================
        // squash and outputs
        // ==============================
        assign killed = squash_i.valid & pktQ.branchMask[squash_i.checkpointId];

        always_comb
        begin
                wbCtrl_o.valid        = pktQ.valid & ~killed;
                wbCtrl_o.activeListId = pktQ.activeListId;
                wbCtrl_o.wbFlags      = pktQ.flags.wbFlags;

                bypass_o.valid        = pktQ.valid & pktQ.flags.bypassEn;      // not squash gated
                bypass_o.physReg      = pktQ.physReg;
                bypass_o.data         = pktQ.data;
        end

        assign held_o = pktQ;                   // feeds branch resolution

endmodule

// File: common/wbPacketPkg.sv
// Writeback packet formats for execution lanes, load/store lane and stage outputs

package wbPacketPkg;

        // ==============================
        // inputs from the functional units
        // ==============================
        typedef struct packed {
                logic                                   mispredict;
                logic                                   conditional;    // conditional branch
                logic                                   bypassEn;       // result goes on bypass
                logic [wbConfigPkg::wbFlagsW-1:0]       wbFlags;
        } execFlags_t;

        typedef struct packed {
                logic                                   valid;
                logic [wbConfigPkg::checkpoints-1:0]    branchMask;     // unresolved branches
                execFlags_t                             flags;
                logic [wbConfigPkg::physRegW-1:0]       physReg;
                logic [wbConfigPkg::activeListW-1:0]    activeListId;
                logic [wbConfigPkg::dataW-1:0]          data;
                logic [wbConfigPkg::checkpointW-1:0]    checkpointId;   // own checkpoint
                logic [wbConfigPkg::ctiW-1:0]           ctiIndex;
                logic [wbConfigPkg::pcW-1:0]            target;
                logic                                   direction;      // taken
        } execPacket_t;

        typedef struct packed {
                logic                                   valid;
                logic [wbConfigPkg::checkpoints-1:0]    branchMask;
                execFlags_t                             flags;
                logic [wbConfigPkg::dataW-1:0]          data;
                logic [wbConfigPkg::physRegW-1:0]       physReg;
                logic [wbConfigPkg::activeListW-1:0]    activeListId;
                logic [wbConfigPkg::issueQW-1:0]        iqEntry;
        } lsuPacket_t;

        typedef struct packed {
                logic                                   valid;
                logic [wbConfigPkg::activeListW-1:0]    activeListId;   // violating load
        } ldViolation_t;

        // ==============================
        // stage outputs
        // ==============================
        typedef struct packed {
                logic                                   valid;
                logic [wbConfigPkg::activeListW-1:0]    activeListId;
                logic [wbConfigPkg::wbFlagsW-1:0]       wbFlags;
        } wbCtrl_t;

        typedef struct packed {
                logic                                   valid;
                logic [wbConfigPkg::physRegW-1:0]       physReg;
                logic [wbConfigPkg::dataW-1:0]          data;
        } bypass_t;

        typedef struct packed {
                logic                                   valid;
                logic [wbConfigPkg::issueQW-1:0]        entry;
        } iqFree_t;

        typedef struct packed {
                logic                                   verified;
                logic                                   mispredict;
                logic                                   conditional;
                logic [wbConfigPkg::checkpointW-1:0]    checkpointId;
                logic [wbConfigPkg::pcW-1:0]            target;
                logic                                   direction;
                logic [wbConfigPkg::ctiW-1:0]           ctiIndex;
        } ctrlResolve_t;

        typedef struct packed {
                logic                                   valid;
                logic [wbConfigPkg::checkpointW-1:0]    checkpointId;   // killed checkpoint
        } squash_t;

endpackage

// File: common/wbConfigPkg.sv
// Writeback core configuration: datapath widths, queue index sizes and lane counts

package wbConfigPkg;

        // ==============================
        // datapath widths
        // ==============================
        localparam int dataW       = 32;        // result word
        localparam int pcW         = 32;        // branch target

        // ==============================
        // rename and queue indices
        // ==============================
        localparam int physRegW    = 7;         // physical register tag
        localparam int activeListW = 7;         // active-list slot
        localparam int issueQW     = 5;         // issue-queue entry
        localparam int ctiW        = 4;         // CTI queue slot

        // branch checkpoints, one mask bit per checkpoint
        localparam int checkpoints = 4;
        localparam int checkpointW = 2;         // log2 of checkpoints

        localparam int wbFlagsW    = 4;         // flags handed to the active list

        // ==============================
        // lane layout
        // ==============================
        localparam int execLanes   = 3;         // lsu lane follows these
        localparam int branchLane  = 2;         // exec lane that resolves branches

endpackage
